// File: hw/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

	// board size in pixels
	localparam int screen_w = 160;
	localparam int screen_h = 120;
	// border band width
	localparam int wall_thick = 2;

	typedef logic [7:0] x_t;
	typedef logic [6:0] y_t;
	typedef logic [2:0] colour_t;

	// colour codes
	localparam colour_t colour_black = 3'b000;
	localparam colour_t colour_blue = 3'b100;
	localparam colour_t colour_yellow = 3'b110;

	// column in the upper byte, row in the low seven bits
	typedef struct packed {
		x_t x;
		y_t y;
	} point_t;

	// one draw beat
	typedef struct packed {
		logic plot;
		point_t point;
		colour_t colour;
	} pixel_t;

	// sweep counter, also read as a board point
	typedef union packed {
		logic [14:0] count;
		point_t point;
	} scan_word_u;

endpackage

`default_nettype wire

// File: hw/game_pkg.sv
`default_nettype none

package game_pkg;

	typedef enum logic [3:0] {
		st_menu,
		st_start,
		st_load,
		st_place,
		st_draw,
		st_delay,
		st_move,
		st_munch,
		st_check,
		st_dead
	} game_state_t;

	typedef enum logic [1:0] {
		dir_left,
		dir_right,
		dir_down,
		dir_up
	} dir_t;

	// button levels, high while held
	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic up;
	} buttons_t;

	typedef logic [1:0] difficulty_t;

	// what the frame scanner sweeps
	typedef enum logic [2:0] {
		scan_idle,
		scan_clear,
		scan_walls,
		scan_apple,
		scan_snake,
		scan_collide
	} scan_phase_t;

	// body store depth
	localparam int max_len = 32;
	typedef logic [4:0] seg_idx_t;
	typedef logic [7:0] size_t;

	// starting snake, head at start_x, tail to the right
	localparam int start_len = 5;
	localparam int start_x = 30;
	localparam int start_y = 20;

	// delay cycles per difficulty, index 0 is the slowest
	localparam logic [3:0][7:0] delay_ticks = {8'd16, 8'd32, 8'd32, 8'd64};

	// apple placement from the raw random word
	localparam int apple_wrap_x = 150;
	localparam int apple_sub_x = 110;
	localparam int apple_add_x = 3;
	localparam int apple_wrap_y = 100;
	localparam int apple_sub_y = 98;
	localparam int apple_add_y = 2;

endpackage

`default_nettype wire

// File: hw/game_control.sv
`default_nettype none
`timescale 1ns/1ps

module game_control (
	input logic clk,
	input logic reset,
	input game_pkg::difficulty_t difficulty,
	input game_pkg::buttons_t buttons,
	input logic [14:0] random_word,
	input pixel_pkg::point_t head,
	input game_pkg::size_t size,
	input logic scan_done,
	input logic collision,
	output game_pkg::scan_phase_t phase,
	output pixel_pkg::point_t apple,
	output pixel_pkg::colour_t apple_colour,
	output logic load,
	output logic step,
	output game_pkg::dir_t dir,
	output logic grow,
	output game_pkg::size_t grow_by,
	output game_pkg::size_t score,
	output game_pkg::size_t best_score,
	output logic game_over
);
	import pixel_pkg::*;
	import game_pkg::*;

	game_state_t state;
	dir_t cur_dir;
	logic [7:0] delay_cnt;
	logic any_button;
	point_t apple_next;
	colour_t colour_next;

	assign any_button = |buttons;

	// steering, reverse presses fall through to the next button
	always_comb begin
		dir = cur_dir;
		if (buttons.left && cur_dir != dir_right)
			dir = dir_left;
		else if (buttons.right && cur_dir != dir_left)
			dir = dir_right;
		else if (buttons.down && cur_dir != dir_up)
			dir = dir_down;
		else if (buttons.up && cur_dir != dir_down)
			dir = dir_up;
	end

	// fold the raw random word onto the playfield
	always_comb begin
		if (random_word[7:0] >= x_t'(apple_wrap_x))
			apple_next.x = random_word[7:0] - x_t'(apple_sub_x);
		else
			apple_next.x = random_word[7:0] + x_t'(apple_add_x);
		if (random_word[14:8] >= y_t'(apple_wrap_y))
			apple_next.y = random_word[14:8] - y_t'(apple_sub_y);
		else
			apple_next.y = random_word[14:8] + y_t'(apple_add_y);
		// black apple would vanish on the cleared board
		colour_next = (apple_next.x[2:0] == 3'b000) ? colour_blue : apple_next.x[2:0];
	end

	// strobes to the body store
	assign load = (state == st_load);
	assign step = (state == st_move);
	assign grow = (state == st_munch);
	// blue apple is worth four
	assign grow_by = size_t'(apple_colour);
	assign score = size - size_t'(start_len);

	always_ff @(posedge clk) begin
		if (state == st_place) begin
			apple <= apple_next;
			apple_colour <= colour_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_menu;
			phase <= scan_idle;
			cur_dir <= dir_left;
			delay_cnt <= '0;
			best_score <= '0;
			game_over <= 1'b0;
		end else begin
			case (state)
				// press then release to begin
				st_menu: if (any_button) state <= st_start;
				st_start: if (!any_button) state <= st_load;
				st_load: begin
					cur_dir <= dir_left;
					game_over <= 1'b0;
					state <= st_place;
				end
				st_place: begin
					state <= st_draw;
					phase <= scan_clear;
				end
				// clear, walls, apple, snake in turn
				st_draw: begin
					if (scan_done) begin
						case (phase)
							scan_clear: phase <= scan_walls;
							scan_walls: phase <= scan_apple;
							scan_apple: phase <= scan_snake;
							default: begin
								phase <= scan_idle;
								delay_cnt <= '0;
								state <= st_delay;
							end
						endcase
					end
				end
				st_delay: begin
					if (delay_cnt == delay_ticks[difficulty] - 8'd1)
						state <= st_move;
					else
						delay_cnt <= delay_cnt + 8'd1;
				end
				// body steps this cycle using dir
				st_move: begin
					cur_dir <= dir;
					state <= st_check;
					phase <= scan_collide;
				end
				st_check: begin
					if (scan_done) begin
						if (collision) begin
							phase <= scan_idle;
							game_over <= 1'b1;
							state <= st_dead;
						end else if (head == apple) begin
							phase <= scan_idle;
							state <= st_munch;
						end else begin
							phase <= scan_clear;
							state <= st_draw;
						end
					end
				end
				st_munch: state <= st_place;
				// keep the better of old best and this game
				st_dead: begin
					if (score > best_score)
						best_score <= score;
					state <= st_menu;
				end
				default: state <= st_menu;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/snake_body.sv
`default_nettype none
`timescale 1ns/1ps

module snake_body (
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	input game_pkg::dir_t dir,
	input logic grow,
	input game_pkg::size_t grow_by,
	input game_pkg::seg_idx_t rd_idx,
	output pixel_pkg::point_t rd_point,
	output pixel_pkg::point_t head,
	output game_pkg::size_t size
);
	import pixel_pkg::*;
	import game_pkg::*;

	// segment 0 is the head
	point_t seg [max_len];
	point_t next_head;
	logic [8:0] grown;

	assign head = seg[0];
	assign rd_point = seg[rd_idx];

	// one pixel from the old head
	always_comb begin
		next_head = seg[0];
		case (dir)
			dir_left: next_head.x = seg[0].x - 8'd1;
			dir_right: next_head.x = seg[0].x + 8'd1;
			dir_down: next_head.y = seg[0].y + 7'd1;
			default: next_head.y = seg[0].y - 7'd1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (load) begin
			// unused slots sit on the tail so growth stays on the board
			for (int i = 0; i < max_len; i++) begin
				if (i < start_len)
					seg[i] <= '{x: x_t'(start_x + i), y: y_t'(start_y)};
				else
					seg[i] <= '{x: x_t'(start_x + start_len - 1), y: y_t'(start_y)};
			end
		end else if (step) begin
			for (int i = max_len - 1; i > 0; i--)
				seg[i] <= seg[i - 1];
			seg[0] <= next_head;
		end
	end

	assign grown = {1'b0, size} + {1'b0, grow_by};

	always_ff @(posedge clk) begin
		if (reset || load)
			size <= size_t'(start_len);
		else if (grow)
			// saturate at the store depth
			size <= (grown > 9'(max_len)) ? size_t'(max_len) : grown[7:0];
	end

endmodule

`default_nettype wire

// File: hw/frame_scanner.sv
`default_nettype none
`timescale 1ns/1ps

module frame_scanner (
	input logic clk,
	input logic reset,
	input game_pkg::scan_phase_t phase,
	input pixel_pkg::point_t apple,
	input pixel_pkg::colour_t apple_colour,
	input pixel_pkg::point_t head,
	input game_pkg::size_t size,
	input pixel_pkg::point_t seg_point,
	output game_pkg::seg_idx_t seg_idx,
	output pixel_pkg::pixel_t pixel,
	output logic done,
	output logic collision
);
	import pixel_pkg::*;
	import game_pkg::*;

	scan_word_u word;
	logic last;
	logic self_hit;

	function automatic logic in_board(point_t p);
		return (p.x < x_t'(screen_w)) && (p.y < y_t'(screen_h));
	endfunction

	// border band, anything off the board counts too
	function automatic logic in_wall(point_t p);
		return (p.x < x_t'(wall_thick)) || (p.x >= x_t'(screen_w - wall_thick)) ||
			(p.y < y_t'(wall_thick)) || (p.y >= y_t'(screen_h - wall_thick));
	endfunction

	// low count bits walk the body store
	assign seg_idx = word.count[4:0];

	// final word of each sweep
	always_comb begin
		case (phase)
			scan_clear, scan_walls: last = (word.count == '1);
			scan_apple: last = 1'b1;
			scan_snake: last = (word.count == 15'(size) - 15'd1);
			// one extra beat for the wall test
			scan_collide: last = (word.count == 15'(size));
			default: last = 1'b0;
		endcase
	end

	// head against any later segment
	assign self_hit = (word.count != '0) && (word.count < 15'(size)) && (seg_point == head);

	always_ff @(posedge clk) begin
		if (reset) begin
			word <= '0;
			pixel <= '0;
			done <= 1'b0;
			collision <= 1'b0;
		end else begin
			done <= 1'b0;
			pixel.plot <= 1'b0;
			// skip the done beat while the controller moves the phase on
			if (!done && phase != scan_idle) begin
				case (phase)
					scan_clear: pixel <= '{plot: in_board(word.point),
						point: word.point, colour: colour_black};
					scan_walls: pixel <= '{plot: in_board(word.point) && in_wall(word.point),
						point: word.point, colour: colour_blue};
					scan_apple: pixel <= '{plot: 1'b1, point: apple, colour: apple_colour};
					scan_snake: pixel <= '{plot: 1'b1, point: seg_point, colour: colour_yellow};
					default: begin
						// fresh sweep starts clean
						if (word.count == '0)
							collision <= 1'b0;
						else if (self_hit || (last && in_wall(head)))
							collision <= 1'b1;
					end
				endcase
				if (last) begin
					word <= '0;
					done <= 1'b1;
				end else begin
					word.count <= word.count + 15'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/snake_game.sv
`default_nettype none
`timescale 1ns/1ps

module snake_game (
	input logic clk,
	input logic reset,
	input game_pkg::difficulty_t difficulty,
	input game_pkg::buttons_t buttons,
	input logic [14:0] random_word,
	output pixel_pkg::pixel_t pixel,
	output game_pkg::size_t score,
	output game_pkg::size_t best_score,
	output logic game_over
);
	import pixel_pkg::*;
	import game_pkg::*;

	// controller to scanner
	scan_phase_t phase;
	point_t apple;
	colour_t apple_colour;
	logic scan_done;
	logic collision;

	// controller to body
	logic load;
	logic step;
	dir_t dir;
	logic grow;
	size_t grow_by;
	point_t head;
	size_t size;

	// scanner to body
	seg_idx_t seg_idx;
	point_t seg_point;

	game_control control0 (
		.clk(clk),
		.reset(reset),
		.difficulty(difficulty),
		.buttons(buttons),
		.random_word(random_word),
		.head(head),
		.size(size),
		.scan_done(scan_done),
		.collision(collision),
		.phase(phase),
		.apple(apple),
		.apple_colour(apple_colour),
		.load(load),
		.step(step),
		.dir(dir),
		.grow(grow),
		.grow_by(grow_by),
		.score(score),
		.best_score(best_score),
		.game_over(game_over)
	);

	snake_body body0 (
		.clk(clk),
		.reset(reset),
		.load(load),
		.step(step),
		.dir(dir),
		.grow(grow),
		.grow_by(grow_by),
		.rd_idx(seg_idx),
		.rd_point(seg_point),
		.head(head),
		.size(size)
	);

	frame_scanner scan0 (
		.clk(clk),
		.reset(reset),
		.phase(phase),
		.apple(apple),
		.apple_colour(apple_colour),
		.head(head),
		.size(size),
		.seg_point(seg_point),
		.seg_idx(seg_idx),
		.pixel(pixel),
		.done(scan_done),
		.collision(collision)
	);

endmodule

`default_nettype wire

// File: verification/snake_checker.sv
`default_nettype none
`timescale 1ns/1ps

module snake_checker (
	input logic clk,
	input logic reset,
	input game_pkg::buttons_t buttons,
	input logic [14:0] random_word,
	input pixel_pkg::pixel_t pixel,
	input game_pkg::size_t score,
	input game_pkg::size_t best_score,
	input logic game_over,
	input game_pkg::size_t expect_score,
	input int expect_frames,
	output int checks,
	output int errors
);
	import pixel_pkg::*;
	import game_pkg::*;

	// model body with the head in slot 0
	point_t body [32];
	dir_t dir_m;
	buttons_t held;
	int size_m;
	int best_m;
	int frame_n;
	int pix_n;
	logic started;
	logic armed;
	logic dead_m;
	logic best_due;
	logic fresh;
	logic go_prev;

	task automatic check_val(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("[ERROR] %0d ns %s expected %0h actual %0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic fail(input string what);
		errors++;
		$display("at %0d ns: %s", $time, what);
	endtask

	// fold column and row of the raw word onto the board
	function automatic pixel_t apple_of(logic [14:0] w);
		pixel_t p;
		p.plot = 1'b1;
		p.point.x = (w[7:0] >= 8'd150) ? w[7:0] - 8'd110 : w[7:0] + 8'd3;
		p.point.y = (w[14:8] >= 7'd100) ? w[14:8] - 7'd98 : w[14:8] + 7'd2;
		// zero colour is drawn blue
		p.colour = (p.point.x[2:0] == 3'd0) ? colour_blue : p.point.x[2:0];
		return p;
	endfunction

	// two pixel band on every edge
	function automatic logic on_border(point_t p);
		return p.x < 8'd2 || p.x > 8'd157 || p.y < 7'd2 || p.y > 7'd117;
	endfunction

	task automatic load_model();
		for (int i = 0; i < 32; i++) begin
			// slots past the tail repeat the tail
			body[i].x = (i < 5) ? x_t'(30 + i) : x_t'(34);
			body[i].y = 7'd20;
		end
		dir_m = dir_left;
		held = '0;
		size_m = 5;
		frame_n = 0;
		pix_n = 0;
		dead_m = 1'b0;
	endtask

	task automatic move_model();
		point_t nh;
		pixel_t a;
		int grow;
		// first pressed button that is not a reversal
		if (held.left && dir_m != dir_right)
			dir_m = dir_left;
		else if (held.right && dir_m != dir_left)
			dir_m = dir_right;
		else if (held.down && dir_m != dir_up)
			dir_m = dir_down;
		else if (held.up && dir_m != dir_down)
			dir_m = dir_up;
		nh = body[0];
		case (dir_m)
			dir_left: nh.x = nh.x - 8'd1;
			dir_right: nh.x = nh.x + 8'd1;
			dir_down: nh.y = nh.y + 7'd1;
			default: nh.y = nh.y - 7'd1;
		endcase
		for (int i = 31; i > 0; i--)
			body[i] = body[i - 1];
		body[0] = nh;
		dead_m = on_border(nh);
		for (int i = 1; i < size_m; i++) begin
			if (body[i] == nh)
				dead_m = 1'b1;
		end
		a = apple_of(random_word);
		grow = (a.colour == 3'd0) ? 4 : int'(a.colour);
		if (!dead_m && nh == a.point)
			size_m = (size_m + grow > 32) ? 32 : size_m + grow;
	endtask

	task automatic end_frame();
		check_val("pixel.plot beats per frame", 20305 + size_m, pix_n);
		move_model();
	endtask

	task automatic take_pixel();
		pixel_t want;
		int s;
		if (pixel.colour == colour_black && pixel.point == '0) begin
			if (frame_n > 0) begin
				end_frame();
				if (dead_m)
					fail("a frame was drawn after a fatal move");
			end
			check_val("game_over", 0, int'(game_over));
			check_val("score", size_m - 5, int'(score));
			frame_n++;
			pix_n = 0;
		end
		// clear sweep runs column by column
		want = '{plot: 1'b1, point: '{x: x_t'(pix_n / 120), y: y_t'(pix_n % 120)},
			colour: colour_black};
		if (pix_n < 19200) begin
			check_val("pixel", int'(want), int'(pixel));
		end else if (pix_n < 20304) begin
			check_val("pixel.colour", int'(colour_blue), int'(pixel.colour));
			if (!on_border(pixel.point) || pixel.point.x > 8'd159 || pixel.point.y > 7'd119)
				fail("a wall pixel lies off the border band");
		end else if (pix_n == 20304) begin
			check_val("pixel", int'(apple_of(random_word)), int'(pixel));
		end else begin
			s = pix_n - 20305;
			// steering held over the snake draw is what the move sees
			held = buttons;
			if (s >= size_m) begin
				fail("more snake pixels than segments");
			end else begin
				want = '{plot: 1'b1, point: body[s], colour: colour_yellow};
				check_val("pixel", int'(want), int'(pixel));
			end
		end
		pix_n++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			checks = 0;
			errors = 0;
			best_m = 0;
			started = 1'b0;
			armed = 1'b0;
			best_due = 1'b0;
			fresh = 1'b1;
			go_prev = 1'b0;
			load_model();
		end else begin
			// outputs just out of reset
			if (fresh) begin
				check_val("pixel.plot", 0, int'(pixel.plot));
				check_val("game_over", 0, int'(game_over));
				check_val("score", 0, int'(score));
				check_val("best_score", 0, int'(best_score));
				fresh = 1'b0;
			end
			// best score settles one beat after game_over
			if (best_due) begin
				check_val("best_score", best_m, int'(best_score));
				best_due = 1'b0;
			end
			// press then release starts a game
			if (!started) begin
				if (buttons != '0) begin
					armed = 1'b1;
				end else if (armed) begin
					armed = 1'b0;
					started = 1'b1;
					load_model();
				end
			end
			if (pixel.plot) begin
				if (!started)
					fail("a pixel was plotted in the menu");
				else
					take_pixel();
			end
			if (game_over && !go_prev) begin
				if (!started || frame_n == 0) begin
					fail("game_over rose outside a game");
				end else begin
					end_frame();
					if (!dead_m)
						fail("game_over rose without a wall or body hit");
					check_val("score", size_m - 5, int'(score));
					check_val("score", int'(expect_score), int'(score));
					check_val("frame count", expect_frames, frame_n);
					if (size_m - 5 > best_m)
						best_m = size_m - 5;
					best_due = 1'b1;
				end
				started = 1'b0;
			end
			go_prev = game_over;
		end
	end

endmodule

`default_nettype wire

// File: verification/snake_tb.sv
`default_nettype none
`timescale 1ns/1ps

// free running clock, 40 ns period
module snake_clock (
	output logic clk
);
	initial clk = 1'b0;
	always #20 clk = ~clk;
endmodule

module snake_tb;
	import pixel_pkg::*;
	import game_pkg::*;

	// columns per test line in the data file
	localparam int fields = 11;
	localparam int max_tests = 16;
	// cycle budget per drawn frame
	localparam int frame_cycles = 70000;

	logic [15:0] tests [max_tests * fields];
	logic clk;
	logic reset;
	difficulty_t difficulty;
	buttons_t buttons;
	logic [14:0] random_word;
	pixel_t pixel;
	size_t score;
	size_t best_score;
	logic game_over;
	size_t expect_score;
	int expect_frames;
	int checks;
	int errors;
	int n_tests;
	int limit;
	int cycles;

	snake_clock clock0 (.clk(clk));

	snake_game dut0 (
		.clk(clk),
		.reset(reset),
		.difficulty(difficulty),
		.buttons(buttons),
		.random_word(random_word),
		.pixel(pixel),
		.score(score),
		.best_score(best_score),
		.game_over(game_over)
	);

	snake_checker check0 (
		.clk(clk),
		.reset(reset),
		.buttons(buttons),
		.random_word(random_word),
		.pixel(pixel),
		.score(score),
		.best_score(best_score),
		.game_over(game_over),
		.expect_score(expect_score),
		.expect_frames(expect_frames),
		.checks(checks),
		.errors(errors)
	);

	// button mask held during one frame, from the three steering columns
	function automatic buttons_t steer_for(input int t, input int frame);
		buttons_t b;
		b = '0;
		for (int e = 0; e < 3; e++) begin
			if (int'(tests[t * fields + 4 + 2 * e]) == frame)
				b = buttons_t'(tests[t * fields + 5 + 2 * e][3:0]);
		end
		return b;
	endfunction

	// one game, from the start press to game_over
	task automatic run_test(input int t);
		int base;
		int frame;
		base = t * fields;
		difficulty = tests[base][1:0];
		random_word = tests[base + 1][14:0];
		expect_frames = int'(tests[base + 3]);
		expect_score = tests[base + 10][7:0];
		// press, hold, let go
		buttons = '{left: 1'b1, default: 1'b0};
		repeat (int'(tests[base + 2])) @(negedge clk);
		buttons = '0;
		// last game's flag drops on load
		while (game_over)
			@(negedge clk);
		frame = 0;
		while (!game_over) begin
			@(negedge clk);
			// black pixel at the origin opens a frame
			if (pixel.plot && pixel.colour == colour_black && pixel.point == '0) begin
				buttons = steer_for(t, frame);
				frame++;
			end
		end
		buttons = '0;
		repeat (4) @(negedge clk);
	endtask

	// run limit grows with the frames listed in the data file
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", limit);
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset = 1'b1;
		difficulty = '0;
		buttons = '0;
		random_word = '0;
		expect_score = '0;
		expect_frames = 0;
		n_tests = 0;
		limit = 0;
		$readmemh("verification/snake_tests.txt", tests);
		// ffff in the first column ends the list
		while (n_tests < max_tests && tests[n_tests * fields] != 16'hffff) begin
			limit += int'(tests[n_tests * fields + 3]) * frame_cycles;
			n_tests++;
		end
		limit += 1000;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		repeat (8) @(negedge clk);
		if (n_tests == 0)
			$display("no tests were read from the data file");
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0 && n_tests > 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/snake_tests.txt
// one game per line, hex: difficulty, random word, start press cycles, frames until death,
// three steering pairs (frame, button mask left=8 right=4 down=2 up=1), final score
// reversal ignored, turn up, blue apple worth 4, die on top wall
0000 0819 0003 0015 0000 0004 0002 0001 ffff 0000 0004
// straight up, yellow apple worth 6
0003 0a1b 0001 0013 0000 0001 ffff 0000 ffff 0000 0006
// wrapped apple placement, run left into the wall
0001 6ea0 0028 001d ffff 0000 ffff 0000 ffff 0000 0000
// up, right, down into its own body
0002 3264 0005 0003 0000 0001 0001 0004 0002 0002 0000
// end of list
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: build.f
hw/pixel_pkg.sv
hw/game_pkg.sv
hw/game_control.sv
hw/snake_body.sv
hw/frame_scanner.sv
hw/snake_game.sv
verification/snake_checker.sv
verification/snake_tb.sv

// File: Makefile
# Verilator build and run of the snake game testbench, from the project root

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, search sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module snake_tb -f build.f -Mdir obj_dir
	./obj_dir/Vsnake_tb | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log
